//--- hdl/spc700_alu.sv
`timescale 1ns/1ps

module spc700_alu (
	input  logic [spc700_pkg::data_width-1:0] reg_a,
	input  logic [spc700_pkg::data_width-1:0] operand,
	input  logic                              carry_in,
	input  spc700_pkg::alu_op_t               alu_op,
	output logic [spc700_pkg::data_width-1:0] result,
	output logic [7:0]                        flags
);
	logic       subtract;  // SBC or CMP.
	logic [7:0] addend;    // Operand, inverted for subtract.
	logic       add_carry; // Carry into bit 0.
	logic [8:0] sum;       // Carry out in bit 8.
	logic [4:0] low_sum;   // Carry out of bit 3 in bit 4.
	logic       overflow;  // Signed overflow of the adder.

	// ==============================
	// Shared adder
	// ==============================

	assign subtract  = (alu_op == spc700_pkg::alu_sub) || (alu_op == spc700_pkg::alu_cmp);
	assign addend    = subtract ? ~operand : operand;
	assign add_carry = (alu_op == spc700_pkg::alu_cmp) ? 1'b1 : carry_in; // CMP ignores C.

	assign sum      = {1'b0, reg_a} + {1'b0, addend} + {8'd0, add_carry};
	assign low_sum  = {1'b0, reg_a[3:0]} + {1'b0, addend[3:0]} + {4'd0, add_carry};
	assign overflow = (reg_a[7] == addend[7]) && (sum[7] != reg_a[7]);

	// ==============================
	// Result select
	// ==============================

	always_comb begin
		case (alu_op)
			spc700_pkg::alu_or:  result = reg_a | operand;
			spc700_pkg::alu_and: result = reg_a & operand;
			spc700_pkg::alu_eor: result = reg_a ^ operand;
			spc700_pkg::alu_add,
			spc700_pkg::alu_sub,
			spc700_pkg::alu_cmp: result = sum[7:0];
			default:             result = operand; // LDA.
		endcase
	end

	// Flags in status positions. Decoder mask picks the ones that apply.
	always_comb begin
		flags                     = 8'h00;
		flags[spc700_pkg::flag_n] = result[7];
		flags[spc700_pkg::flag_z] = (result == 8'h00);
		flags[spc700_pkg::flag_v] = overflow;
		flags[spc700_pkg::flag_h] = low_sum[4];
		flags[spc700_pkg::flag_c] = sum[8]; // Set means no borrow on subtract.
		flags[spc700_pkg::flag_b] = 1'b0;
		flags[spc700_pkg::flag_p] = 1'b0;
		flags[spc700_pkg::flag_i] = 1'b0;
	end

endmodule

//--- hdl/spc700_core.sv
`timescale 1ns/1ps

module spc700_core (
	input  logic                                clock,
	input  logic                                reset,
	output logic [spc700_pkg::addr_width-1:0]   ram_address,
	input  logic [spc700_pkg::data_width-1:0]   ram_read,
	output logic                                halted,
	output logic [spc700_pkg::data_width-1:0]   reg_a,
	output logic [spc700_pkg::data_width-1:0]   psw
);
	// ==============================
	// Internal wires
	// ==============================

	logic       needs_operand;  // Opcode has a second byte.
	logic       is_branch;      // Opcode is a relative branch.
	logic       illegal;        // Opcode not supported.
	logic [2:0] branch_flag;    // Status bit tested by the branch.
	logic       branch_if_set;  // Branch polarity.
	logic       opcode_valid;   // Opcode byte on ram_read.
	logic [7:0] operand;        // Latched immediate or offset.
	logic       exec;           // Commit strobe.

	spc700_pkg::alu_op_t alu_op;
	logic       write_a;        // Result goes to A.
	logic       flags_from_alu; // Status from ALU, else constant.
	logic [7:0] status_mask;    // Status bits to update.
	logic [7:0] status_value;   // Constant for flag instructions.
	logic [7:0] alu_result;
	logic [7:0] alu_flags;

	spc700_sequencer i_sequencer (
		.clock, .reset,
		.ram_read, .psw,
		.needs_operand, .is_branch, .illegal,
		.branch_flag, .branch_if_set,
		.ram_address,
		.opcode_valid, .operand,
		.exec, .halted
	);

	spc700_decoder i_decoder (
		.clock, .reset,
		.ram_read, .opcode_valid,
		.needs_operand, .is_branch, .illegal,
		.branch_flag, .branch_if_set,
		.alu_op, .write_a, .flags_from_alu,
		.status_mask, .status_value
	);

	spc700_alu i_alu (
		.reg_a, .operand,
		.carry_in (psw[spc700_pkg::flag_c]), // ADC and SBC carry.
		.alu_op,
		.result   (alu_result),
		.flags    (alu_flags)
	);

	spc700_registers i_registers (
		.clock, .reset, .exec,
		.write_a, .result (alu_result),
		.flags_from_alu, .alu_flags,
		.status_mask, .status_value,
		.reg_a, .psw
	);

endmodule

//--- hdl/spc700_decoder.sv
`timescale 1ns/1ps

module spc700_decoder (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [spc700_pkg::data_width-1:0] ram_read,
	input  logic                              opcode_valid,
	output logic                              needs_operand,
	output logic                              is_branch,
	output logic                              illegal,
	output logic [2:0]                        branch_flag,
	output logic                              branch_if_set,
	output spc700_pkg::alu_op_t               alu_op,
	output logic                              write_a,
	output logic                              flags_from_alu,
	output logic [7:0]                        status_mask,
	output logic [7:0]                        status_value
);
	spc700_pkg::opcode_t opcode;

	// Next control word, latched on opcode_valid.
	spc700_pkg::alu_op_t d_alu_op;
	logic       d_write_a;
	logic       d_flags_from_alu;
	logic [7:0] d_status_mask;
	logic [7:0] d_status_value;
	logic [2:0] d_branch_flag;
	logic       d_branch_if_set;

	assign opcode = ram_read;

	// ==============================
	// Combinational decode
	// ==============================

	always_comb begin
		needs_operand    = 1'b0;
		is_branch        = 1'b0;
		illegal          = 1'b0;
		d_alu_op         = spc700_pkg::alu_pass;
		d_write_a        = 1'b0;
		d_flags_from_alu = 1'b0;
		d_status_mask    = 8'h00;
		d_status_value   = 8'h00;
		d_branch_flag    = 3'(spc700_pkg::flag_n);
		d_branch_if_set  = 1'b0;

		if (opcode.fields.set != 2'b00 || opcode.raw == spc700_pkg::op_cpx) begin
			illegal = 1'b1; // Other sets and CPX are not kept.
		end else begin
			case (opcode.fields.column)
				spc700_pkg::col_status: begin
					case (opcode.fields.row)
						3'd1, 3'd2: d_status_mask[spc700_pkg::flag_p] = 1'b1; // CLP, SEP.
						3'd3, 3'd4: d_status_mask[spc700_pkg::flag_c] = 1'b1; // CLC, SEC.
						3'd5, 3'd6: d_status_mask[spc700_pkg::flag_i] = 1'b1; // CLI, SEI.
						3'd7:       d_status_mask[spc700_pkg::flag_v] = 1'b1; // CLV.
						default:    d_status_mask = 8'h00;                     // NOP.
					endcase
					// Even rows set the bit.
					if (!opcode.fields.row[0]) d_status_value = d_status_mask;
				end

				spc700_pkg::col_branch: begin
					needs_operand = 1'b1;
					is_branch     = 1'b1;
					case (opcode.fields.row[2:1])
						2'd0:    d_branch_flag = 3'(spc700_pkg::flag_n);
						2'd1:    d_branch_flag = 3'(spc700_pkg::flag_v);
						2'd2:    d_branch_flag = 3'(spc700_pkg::flag_c);
						default: d_branch_flag = 3'(spc700_pkg::flag_z);
					endcase
					d_branch_if_set = opcode.fields.row[0]; // Odd rows branch on set.
				end

				spc700_pkg::col_imm: begin
					needs_operand    = 1'b1;
					d_flags_from_alu = 1'b1;
					d_write_a        = 1'b1;
					d_status_mask    = spc700_pkg::mask_nz;
					case (opcode.fields.row)
						3'd0: d_alu_op = spc700_pkg::alu_or;
						3'd1: d_alu_op = spc700_pkg::alu_and;
						3'd2: d_alu_op = spc700_pkg::alu_eor;
						3'd3: begin
							d_alu_op      = spc700_pkg::alu_cmp;
							d_write_a     = 1'b0; // Compare only.
							d_status_mask = spc700_pkg::mask_nzc;
						end
						3'd4: begin
							d_alu_op      = spc700_pkg::alu_add;
							d_status_mask = spc700_pkg::mask_nvhzc;
						end
						3'd5: begin
							d_alu_op      = spc700_pkg::alu_sub;
							d_status_mask = spc700_pkg::mask_nvhzc;
						end
						default: d_alu_op = spc700_pkg::alu_pass; // LDA.
					endcase
				end

				default: illegal = 1'b1;
			endcase
		end
	end

	// ==============================
	// Execute control word
	// ==============================

	always_ff @(posedge clock) begin
		if (reset) begin
			alu_op         <= spc700_pkg::alu_pass;
			write_a        <= 1'b0;
			flags_from_alu <= 1'b0;
			status_mask    <= 8'h00;
			status_value   <= 8'h00;
			branch_flag    <= 3'd0;
			branch_if_set  <= 1'b0;
		end else if (opcode_valid) begin
			alu_op         <= d_alu_op;
			write_a        <= d_write_a;
			flags_from_alu <= d_flags_from_alu;
			status_mask    <= d_status_mask;
			status_value   <= d_status_value;
			branch_flag    <= d_branch_flag;
			branch_if_set  <= d_branch_if_set;
		end
	end

	a_illegal_no_operand: assert property (@(posedge clock) disable iff (reset)
		opcode_valid |-> !(illegal && needs_operand));

endmodule

//--- hdl/spc700_pkg.sv
package spc700_pkg;

	// ==============================
	// Bus and reset
	// ==============================

	localparam int addr_width = 16; // Program address width.
	localparam int data_width = 8;  // Byte bus width.

	localparam logic [addr_width-1:0] reset_pc = 16'h0000; // First fetch address.

	// Bus phase ring bit indexes, one-hot.
	localparam int phase_master = 0; // Address driven.
	localparam int phase_wait   = 1; // Memory lookup.
	localparam int phase_result = 2; // Read data valid.

	// ==============================
	// Status word
	// ==============================

	localparam int flag_c = 0; // Carry.
	localparam int flag_z = 1; // Zero.
	localparam int flag_i = 2; // Interrupt enable.
	localparam int flag_h = 3; // Half carry.
	localparam int flag_b = 4; // Break, never set here.
	localparam int flag_p = 5; // Direct page.
	localparam int flag_v = 6; // Overflow.
	localparam int flag_n = 7; // Negative.

	localparam logic [7:0] mask_nz    = (8'd1 << flag_n) | (8'd1 << flag_z);
	localparam logic [7:0] mask_nzc   = mask_nz | (8'd1 << flag_c);
	localparam logic [7:0] mask_nvhzc = mask_nzc | (8'd1 << flag_v) | (8'd1 << flag_h);

	// ==============================
	// Opcode layout
	// ==============================

	// Column codes of the XXX_YYY_ZZ split, all in set 0.
	localparam logic [2:0] col_status = 3'b000; // Flag set and clear.
	localparam logic [2:0] col_imm    = 3'b010; // Accumulator immediate ops.
	localparam logic [2:0] col_branch = 3'b100; // Relative branches.

	localparam logic [7:0] op_cpx = 8'b110_010_00; // Immediate slot without X register.

	typedef enum logic [2:0] {
		alu_or,
		alu_and,
		alu_eor,
		alu_add,
		alu_sub,
		alu_cmp,
		alu_pass
	} alu_op_t;

	// One opcode byte, seen either whole or as row, column and set.
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] row;    // Operation, or flag for branches.
			logic [2:0] column; // Instruction group.
			logic [1:0] set;    // Column set.
		} fields;
	} opcode_t;

endpackage

//--- hdl/spc700_registers.sv
`timescale 1ns/1ps

module spc700_registers (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              exec,
	input  logic                              write_a,
	input  logic [spc700_pkg::data_width-1:0] result,
	input  logic                              flags_from_alu,
	input  logic [7:0]                        alu_flags,
	input  logic [7:0]                        status_mask,
	input  logic [7:0]                        status_value,
	output logic [spc700_pkg::data_width-1:0] reg_a,
	output logic [spc700_pkg::data_width-1:0] psw
);
	logic [7:0] new_flags; // Source of updated status bits.

	assign new_flags = flags_from_alu ? alu_flags : status_value;

	// ==============================
	// Accumulator and status word
	// ==============================

	always_ff @(posedge clock) begin
		if (reset) begin
			reg_a <= 8'h00;
			psw   <= 8'h00;
		end else if (exec) begin
			if (write_a) begin
				reg_a <= result;
			end
			// Masked bits take the new value, the rest hold.
			psw <= (psw & ~status_mask) | (new_flags & status_mask);
		end
	end

	a_psw_exec_only: assert property (@(posedge clock) disable iff (reset)
		!exec |=> $stable(psw));

endmodule

//--- hdl/spc700_sequencer.sv
`timescale 1ns/1ps

module spc700_sequencer (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [spc700_pkg::data_width-1:0] ram_read,
	input  logic [spc700_pkg::data_width-1:0] psw,
	input  logic                              needs_operand,
	input  logic                              is_branch,
	input  logic                              illegal,
	input  logic [2:0]                        branch_flag,
	input  logic                              branch_if_set,
	output logic [spc700_pkg::addr_width-1:0] ram_address,
	output logic                              opcode_valid,
	output logic [spc700_pkg::data_width-1:0] operand,
	output logic                              exec,
	output logic                              halted
);
	logic [2:0] phase;        // One-hot bus phase ring.
	logic fetching_operand;   // Current slot reads the operand byte.
	logic branch_pending;     // Instruction in flight is a branch.
	logic result_edge;        // Live result phase.
	logic branch_taken;       // Flag matches polarity.
	logic [spc700_pkg::addr_width-1:0] next_address; // Sequential fetch.
	logic [spc700_pkg::addr_width-1:0] branch_target; // After offset plus offset.

	// ==============================
	// Bus phase ring
	// ==============================

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= 3'b000;
			phase[spc700_pkg::phase_master] <= 1'b1; // First cycle is master.
		end else begin
			phase <= {phase[1:0], phase[2]}; // Master, wait, result.
		end
	end

	assign result_edge  = phase[spc700_pkg::phase_result] & ~halted;
	assign opcode_valid = result_edge & ~fetching_operand;

	// ==============================
	// Address and branch
	// ==============================

	assign next_address = ram_address + 16'd1;

	// Offset byte is on ram_read at the operand result edge.
	assign branch_target = next_address +
		{{(spc700_pkg::addr_width - spc700_pkg::data_width){ram_read[7]}}, ram_read};

	assign branch_taken = branch_pending & (psw[branch_flag] == branch_if_set);

	// ==============================
	// Instruction state machine
	// ==============================

	always_ff @(posedge clock) begin
		if (reset) begin
			ram_address      <= spc700_pkg::reset_pc;
			fetching_operand <= 1'b0;
			branch_pending   <= 1'b0;
			exec             <= 1'b0;
			halted           <= 1'b0;
		end else begin
			exec <= 1'b0; // One-cycle strobe.
			if (result_edge) begin
				if (!fetching_operand) begin
					if (illegal) begin
						halted <= 1'b1; // Address stays frozen from here.
					end else begin
						ram_address      <= next_address;
						fetching_operand <= needs_operand;
						branch_pending   <= is_branch;
						exec             <= ~needs_operand; // One-slot instruction done.
					end
				end else begin
					fetching_operand <= 1'b0;
					ram_address      <= branch_taken ? branch_target : next_address;
					exec             <= 1'b1;
				end
			end
		end
	end

	// Immediate or branch offset, held through exec.
	always_ff @(posedge clock) begin
		if (result_edge && fetching_operand) begin
			operand <= ram_read;
		end
	end

	// ==============================
	// Checks
	// ==============================

	a_phase_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot(phase));

	// Address may only move on the edge that opens a slot.
	a_address_slot: assert property (@(posedge clock) disable iff (reset)
		!$stable(ram_address) |-> phase[spc700_pkg::phase_master]);

	a_exec_master: assert property (@(posedge clock) disable iff (reset)
		exec |-> phase[spc700_pkg::phase_master]);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPC700 core simulation with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	-f spc700_core.f \
	--top-module tb_spc700_core \
	-o tb_spc700_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_spc700_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/spc700_ram_model.sv
`timescale 1ns/1ps

module spc700_ram_model (
	input  logic        clock,
	input  logic [15:0] address,
	output logic [7:0]  read_data
);
	logic [7:0] mem [0:65535]; // Program memory, loaded by the testbench.

	// ==============================
	// Background fill
	// ==============================

	initial begin
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a; // Depends on all address bits.
		end
		read_data <= 8'h00;
	end

	// One-cycle registered read.
	always @(posedge clock) begin
		read_data <= mem[address];
	end

endmodule

//--- sim/tb_spc700_core.sv
`timescale 1ns/1ps

module tb_spc700_core;

	logic        clock;
	logic        reset;
	logic [15:0] ram_address;
	logic [7:0]  ram_read;
	logic        halted;
	logic [7:0]  reg_a;
	logic [7:0]  psw;

	logic [7:0]  prog [0:65535]; // Reference copy of the program.
	int          prog_len;
	logic        prog_ready;
	logic [1:0]  branch_hit [0:7]; // Bit 1 taken, bit 0 not taken.

	// Reference model state.
	logic [15:0] exp_address;
	logic [7:0]  exp_a;
	logic [7:0]  exp_psw;
	logic        exp_halted;
	logic [1:0]  m_phase;       // 0 master, 1 wait, 2 result.
	logic        m_operand;     // Current slot reads the operand.
	logic        m_pending;     // Exec due at the next edge.
	logic [7:0]  m_op;
	logic [7:0]  m_value;

	spc700_core i_dut (
		.clock, .reset, .ram_address, .ram_read, .halted, .reg_a, .psw
	);

	spc700_ram_model i_ram (.clock, .address (ram_address), .read_data (ram_read));

	always #4 clock = ~clock; // 8 ns period.

	// ==============================
	// Opcode rules
	// ==============================

	function automatic logic is_illegal(input logic [7:0] op);
		return op[1:0] != 2'b00 || op == 8'hc8 ||
			!(op[4:2] == 3'b000 || op[4:2] == 3'b010 || op[4:2] == 3'b100);
	endfunction

	// Even rows branch on a clear flag, odd rows on a set one.
	function automatic logic branch_taken(input logic [7:0] op, input logic [7:0] p);
		logic flag;
		case (op[7:6])
			2'd0:    flag = p[7]; // N.
			2'd1:    flag = p[6]; // V.
			2'd2:    flag = p[0]; // C.
			default: flag = p[1]; // Z.
		endcase
		return flag == op[5];
	endfunction

	// Returns {A, PSW} after the instruction.
	function automatic logic [15:0] exec_result(input logic [7:0] op, input logic [7:0] v,
			input logic [7:0] a, input logic [7:0] p);
		logic [8:0] wide;
		logic [7:0] w;
		logic [7:0] r;
		logic [7:0] s;
		int         signed_sum;
		r = a;
		s = p;
		w = (op[7:5] == 3'd5) ? ~v : v; // SBC adds the inverted operand.
		wide = {1'b0, a} + {1'b0, w} + {8'd0, p[0]};
		signed_sum = int'($signed(a)) + int'($signed(w)) + int'(p[0]);
		if (op[4:2] == 3'b000) begin
			case (op[7:5])
				3'd1: s[5] = 1'b0;
				3'd2: s[5] = 1'b1;
				3'd3: s[0] = 1'b0;
				3'd4: s[0] = 1'b1;
				3'd5: s[2] = 1'b0;
				3'd6: s[2] = 1'b1;
				3'd7: s[6] = 1'b0;
				default: s = p; // NOP.
			endcase
		end else if (op[4:2] == 3'b010) begin
			case (op[7:5])
				3'd0: r = a | v;
				3'd1: r = a & v;
				3'd2: r = a ^ v;
				3'd3: begin
					r = a - v; // CMP result only feeds flags.
					s[0] = a >= v;
				end
				3'd4, 3'd5: begin
					r = wide[7:0];
					s[0] = wide[8];
					s[3] = (5'(a[3:0]) + 5'(w[3:0]) + 5'(p[0])) > 5'd15; // Old carry in.
					s[6] = (signed_sum > 127) || (signed_sum < -128);
				end
				default: r = v; // LDA.
			endcase
			s[7] = r[7];
			s[1] = (r == 8'h00);
			if (op[7:5] == 3'd3) begin
				r = a; // Compare leaves A alone.
			end
		end
		return {r, s};
	endfunction

	// ==============================
	// Reference model
	// ==============================

	always @(posedge clock) begin
		if (reset) begin
			exp_address <= 16'h0000;
			exp_a       <= 8'h00;
			exp_psw     <= 8'h00;
			exp_halted  <= 1'b0;
			m_phase     <= 2'd0;
			m_operand   <= 1'b0;
			m_pending   <= 1'b0;
			for (int i = 0; i < 8; i++) begin
				branch_hit[i] <= 2'b00;
			end
		end else begin
			m_phase   <= (m_phase == 2'd2) ? 2'd0 : m_phase + 2'd1;
			m_pending <= 1'b0;
			if (m_pending) begin
				{exp_a, exp_psw} <= exec_result(m_op, m_value, exp_a, exp_psw);
			end
			if (m_phase == 2'd2 && !exp_halted) begin
				if (!m_operand) begin
					m_op <= prog[exp_address];
					if (is_illegal(prog[exp_address])) begin
						exp_halted <= 1'b1;
					end else begin
						exp_address <= exp_address + 16'd1;
						m_operand   <= prog[exp_address][4:2] != 3'b000;
						m_pending   <= prog[exp_address][4:2] == 3'b000;
					end
				end else begin
					m_operand <= 1'b0;
					m_pending <= 1'b1;
					m_value   <= prog[exp_address];
					if (m_op[4:2] == 3'b100 && branch_taken(m_op, exp_psw)) begin
						exp_address <= exp_address + 16'd1 +
							{{8{prog[exp_address][7]}}, prog[exp_address]};
						branch_hit[m_op[7:5]][1] <= 1'b1;
					end else begin
						exp_address <= exp_address + 16'd1;
						if (m_op[4:2] == 3'b100) begin
							branch_hit[m_op[7:5]][0] <= 1'b1;
						end
					end
				end
			end
		end
	end

	// ==============================
	// Checks
	// ==============================

	task automatic report_mismatch(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		$display("[ERROR] %0d ns %s expected %h got %h", $time, name, expected, actual);
		$display("*** TEST FAILED ***");
		$fatal(1, "Mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("[ERROR] %0d ns %s", $time, what);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", what);
	endtask

	a_address: assert property (@(posedge clock) disable iff (reset)
		ram_address == exp_address)
		else report_mismatch("ram_address", $sampled(exp_address), $sampled(ram_address));

	a_halted: assert property (@(posedge clock) disable iff (reset)
		halted == exp_halted)
		else report_mismatch("halted", 16'($sampled(exp_halted)), 16'($sampled(halted)));

	a_reg_a: assert property (@(posedge clock) disable iff (reset)
		reg_a == exp_a)
		else report_mismatch("reg_a", 16'($sampled(exp_a)), 16'($sampled(reg_a)));

	a_psw: assert property (@(posedge clock) disable iff (reset)
		psw == exp_psw)
		else report_mismatch("psw", 16'($sampled(exp_psw)), 16'($sampled(psw)));

	// Once halted nothing on the bus moves.
	a_frozen: assert property (@(posedge clock) disable iff (reset)
		halted |=> $stable(ram_address) && $stable(reg_a) && $stable(psw))
		else report_failure("ram_address, reg_a or psw changed after halt");

	// ==============================
	// Program build
	// ==============================

	task automatic emit(input logic [7:0] value);
		prog[16'(prog_len)] = value;
		prog_len++;
	endtask

	// Drives the flag tested by a branch row to the given value.
	task automatic set_flag(input int row, input logic value);
		case (row / 2)
			0: emit(8'he8);                                   // LDA sets N.
			1: begin
				if (value) begin
					emit(8'he8); // LDA #$40.
					emit(8'h40);
					emit(8'h60); // CLC.
					emit(8'h88); // ADC #$40 overflows.
					emit(8'h40);
				end else begin
					emit(8'he0);                              // CLV.
				end
			end
			2: emit(value ? 8'h80 : 8'h60);                  // SEC or CLC.
			default: emit(8'he8);                             // LDA sets Z.
		endcase
		if (row / 2 == 0) begin
			emit(value ? 8'($urandom) | 8'h80 : 8'($urandom) & 8'h7f);
		end else if (row / 2 == 3) begin
			emit(value ? 8'h00 : 8'($urandom) | 8'h01);
		end
	endtask

	task automatic build_program();
		logic [7:0] fillers [0:4];
		logic [7:0] imm_ops [0:6];
		int skip;
		fillers = '{8'h00, 8'h20, 8'h40, 8'ha0, 8'hc0};
		imm_ops = '{8'h08, 8'h28, 8'h48, 8'h68, 8'h88, 8'ha8, 8'he8};
		prog_len = 0;
		for (int row = 0; row < 8; row++) begin
			for (int value = 0; value < 2; value++) begin
				set_flag(row, value[0]);
				skip = $urandom % 4;
				emit(8'((row << 5) | 8'h10));
				emit(8'(skip));
				for (int k = 0; k < skip; k++) begin
					emit(fillers[3'($urandom % 5)]);
				end
			end
		end
		for (int row = 0; row < 8; row++) begin
			emit(8'(row << 5)); // Whole status column, NOP first.
		end
		for (int n = 0; n < 32; n++) begin
			if ($urandom % 4 == 0) begin
				emit(($urandom % 2) ? 8'h80 : 8'h60); // Random carry in.
			end
			emit(imm_ops[3'(n % 7)]);
			emit(8'($urandom));
		end
		emit(8'hff); // Illegal, halts the core.
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		void'($urandom(32'h6a1a));
		clock      = 1'b0;
		reset      = 1'b1;
		prog_ready = 1'b0;
		@(negedge clock);
		for (int i = 0; i < 65536; i++) begin
			prog[i] = i_ram.mem[i];
		end
		build_program();
		for (int i = 0; i < prog_len; i++) begin
			i_ram.mem[i] = prog[i];
		end
		prog_ready = 1'b1;
		repeat (7) @(negedge clock);
		reset = 1'b0;
		wait (halted);
		repeat (24) @(negedge clock);
		if (branch_hit.and() == 2'b11) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			report_failure("some branch was not seen both taken and not taken");
		end
	end

	// At most three cycles per byte, so twenty per byte leaves plenty of room.
	initial begin
		wait (prog_ready);
		#(prog_len * 20 * 8 + 2000);
		$display("Timeout, the core never halted on the illegal opcode");
		$display("*** TEST FAILED ***");
		$fatal(1, "Watchdog expired");
	end

endmodule

//--- spc700_core.f
hdl/spc700_pkg.sv
hdl/spc700_alu.sv
hdl/spc700_registers.sv
hdl/spc700_decoder.sv
hdl/spc700_sequencer.sv
hdl/spc700_core.sv
sim/spc700_ram_model.sv
sim/tb_spc700_core.sv
